// File: Makefile
SRCS := $(wildcard verilog/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: obj_dir/VreqTrackerTb

obj_dir/VreqTrackerTb: build.f $(SRCS)
	verilator --binary --timing --assert -j 0 -Mdir obj_dir \
		--top-module reqTrackerTb -f build.f

run: obj_dir/VreqTrackerTb
	./obj_dir/VreqTrackerTb | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
verilog/trackPkg.sv
verilog/heapMulti.sv
verilog/reqIssue.sv
verilog/rspMatch.sv
verilog/reqTracker.sv
verification/reqTracker_chk.sv
verification/reqTrackerTb.sv

// File: verification/reqTrackerTb.sv
`timescale 1ns/10ps

module reqTrackerTb;

    localparam int kSeqReqs = 20;
    localparam int kRandReqs = 300;
    localparam int kFillReqs = 40;
    localparam int kMaxLat = 12;
    // Every request at worst latency plus reset and drain margin
    localparam int kCycleLimit = (kSeqReqs + kRandReqs + kFillReqs) * (kMaxLat + 1) + 2000;
    localparam int kLanes = trackPkg::kNumRspPorts;
    localparam int kSlots = trackPkg::kNumEntries;

    logic clk;
    logic resetb;
    logic reqEn;
    trackPkg::reqInfoT reqInfo;
    logic reqReady;
    logic memReqEn;
    trackPkg::memReqT memReq;
    logic memAlmostFull;
    logic memRspEn [kLanes];
    trackPkg::memRspT memRsp [kLanes];
    logic rspEn [kLanes];
    trackPkg::clientRspT rsp [kLanes];
    logic [trackPkg::kIdxBits:0] outstanding;

    // Model of slots, tags and the memory
    logic [31:0] rng;
    trackPkg::reqInfoT infoTable [kSlots];
    logic [kSlots-1:0] busy;
    trackPkg::idxT nextTag;
    int tbOut;
    logic issuePend;
    trackPkg::idxT issueTag;
    trackPkg::reqInfoT issueInfo;
    logic memLive [kSlots];
    int memDue [kSlots];
    logic [trackPkg::kAddrBits-1:0] memAddr [kSlots];
    logic expVal [kLanes];
    trackPkg::clientRspT expRsp [kLanes];

    // Test control changes only at negedge
    bit running;
    bit hold;
    int budget;
    int reqPct;
    int afPct;
    int maxLat;

    int cycle;
    int errCount;
    int errStart;
    int checkCount;
    int testCount;
    int lowSeen;
    string curTest;

    reqTracker i_dut
    (
        .clk(clk),
        .resetb(resetb),
        .reqEn(reqEn),
        .reqInfo(reqInfo),
        .reqReady(reqReady),
        .memReqEn(memReqEn),
        .memReq(memReq),
        .memAlmostFull(memAlmostFull),
        .memRspEn(memRspEn),
        .memRsp(memRsp),
        .rspEn(rspEn),
        .rsp(rsp),
        .outstanding(outstanding)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int randBelow(int n);
        rng = xorshift(rng);
        return int'(rng % 32'(n));
    endfunction

    // Read data the memory returns for an address
    function automatic logic [31:0] addrHash(logic [trackPkg::kAddrBits-1:0] addr);
        return {addr, addr[19:8]} ^ 32'h9e3779b9;
    endfunction

    // Ready needs a free window at the pointer and no memory back-pressure
    function automatic logic readyRef(logic [kSlots-1:0] map, trackPkg::idxT ptr, logic af);
        for (int k = 0; k < trackPkg::kMinFreeSlots; k++)
        begin
            if (map[(int'(ptr) + k) % kSlots])
            begin
                return 1'b0;
            end
        end
        return !af;
    endfunction

    // Expected client response for a returned tag
    function automatic trackPkg::clientRspT expectRsp(trackPkg::idxT tag);
        trackPkg::clientRspT r;
        r.info = infoTable[tag];
        r.data = addrHash(infoTable[tag].addr);
        return r;
    endfunction

    task automatic compare(string what, logic [63:0] expV, logic [63:0] actV);
        checkCount++;
        assert (expV === actV)
        else
        begin
            errCount++;
            $display("ERR %s %s expected %h actual %h", curTest, what, expV, actV);
        end
    endtask

    task automatic startTest(string name);
        curTest = name;
        errStart = errCount;
    endtask

    task automatic endTest();
        testCount++;
        $display("test %-12s %0d errors", curTest, errCount - errStart);
    endtask

    // Wait until every request went out and came back
    task automatic drain();
        while (budget != 0 || tbOut != 0 || issuePend || expVal[0] || expVal[1])
        begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // ==============================
    // Model, compare and drive
    // ==============================

    always @(posedge clk)
    begin
        logic accept;
        logic afNext;
        logic go;
        int picked;
        int start;
        trackPkg::idxT t;
        trackPkg::idxT pickTag [kLanes];
        cycle = cycle + 1;
        if (running)
        begin
            compare("reqReady", 64'(readyRef(busy, nextTag, memAlmostFull)), 64'(reqReady));
            compare("outstanding", 64'(tbOut), 64'(outstanding));
            if (!reqReady)
            begin
                lowSeen++;
            end
            // Issued request fills the tag table and the memory
            if (memReqEn)
            begin
                assert (issuePend)
                else
                begin
                    errCount++;
                    $display("%s: memory request without an accepted request", curTest);
                end
                compare("memReq.tag", 64'(issueTag), 64'(memReq.tag));
                compare("memReq.addr", 64'(issueInfo.addr), 64'(memReq.addr));
                infoTable[memReq.tag] = issueInfo;
                memLive[memReq.tag] = 1'b1;
                memDue[memReq.tag] = cycle + 1 + randBelow(maxLat);
                memAddr[memReq.tag] = memReq.addr;
            end
            else
            begin
                assert (!issuePend)
                else
                begin
                    errCount++;
                    $display("%s: accepted request never reached the memory", curTest);
                end
            end
            for (int p = 0; p < kLanes; p++)
            begin
                if (rspEn[p])
                begin
                    assert (expVal[p])
                    else
                    begin
                        errCount++;
                        $display("%s: response on idle tag, lane %0d", curTest, p);
                    end
                    if (expVal[p])
                    begin
                        compare("rsp", 64'(expRsp[p]), 64'(rsp[p]));
                    end
                end
                else
                begin
                    assert (!expVal[p])
                    else
                    begin
                        errCount++;
                        $display("%s: missing response on lane %0d", curTest, p);
                    end
                end
            end

            // State after this edge
            accept = reqEn && reqReady;
            issuePend = accept;
            if (accept)
            begin
                issueTag = nextTag;
                issueInfo = reqInfo;
                busy[nextTag] = 1'b1;
                nextTag = nextTag + 1'b1;
                tbOut++;
            end
            for (int p = 0; p < kLanes; p++)
            begin
                expVal[p] = memRspEn[p];
                if (memRspEn[p])
                begin
                    t = memRsp[p].tag;
                    expRsp[p] = expectRsp(t);
                    busy[t] = 1'b0;
                    tbOut--;
                end
            end

            // Next client request only where ready is certain
            afNext = randBelow(100) < afPct;
            memAlmostFull <= afNext;
            go = budget > 0 && readyRef(busy, nextTag, afNext) && randBelow(100) < reqPct;
            reqEn <= go;
            reqInfo <= trackPkg::reqInfoT'(xorshift(rng ^ 32'h1234567));
            if (go)
            begin
                budget--;
            end

            // Memory scans due tags from a random start so the order varies
            picked = 0;
            start = randBelow(kSlots);
            for (int k = 0; k < kSlots; k++)
            begin
                t = trackPkg::idxT'((start + k) % kSlots);
                if (!hold && picked < kLanes && memLive[t] && memDue[t] <= cycle)
                begin
                    pickTag[picked] = t;
                    memLive[t] = 1'b0;
                    picked++;
                end
            end
            for (int p = 0; p < kLanes; p++)
            begin
                memRspEn[p] <= 1'b0;
            end
            if (picked == 1)
            begin
                t = pickTag[0];
                start = randBelow(kLanes);
                memRspEn[start] <= 1'b1;
                memRsp[start] <= '{tag: t, data: addrHash(memAddr[t])};
            end
            else if (picked == 2)
            begin
                for (int p = 0; p < kLanes; p++)
                begin
                    t = pickTag[p];
                    memRspEn[p] <= 1'b1;
                    memRsp[p] <= '{tag: t, data: addrHash(memAddr[t])};
                end
            end
        end
        else
        begin
            reqEn <= 1'b0;
            memAlmostFull <= 1'b0;
            for (int p = 0; p < kLanes; p++)
            begin
                memRspEn[p] <= 1'b0;
            end
        end
    end

    // Run limit
    always @(negedge clk)
    begin
        if (cycle >= kCycleLimit)
        begin
            $display("Timeout after %0d cycles in test %s", cycle, curTest);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==============================
    // Tests
    // ==============================

    initial
    begin
        resetb = 1'b0;
        reqEn = 1'b0;
        reqInfo = '0;
        memAlmostFull = 1'b0;
        for (int p = 0; p < kLanes; p++)
        begin
            memRspEn[p] = 1'b0;
            memRsp[p] = '0;
            expVal[p] = 1'b0;
        end
        for (int i = 0; i < kSlots; i++)
        begin
            memLive[i] = 1'b0;
            memDue[i] = 0;
        end
        rng = 32'hdbea5549;
        busy = '0;
        nextTag = '0;
        issuePend = 1'b0;
        tbOut = 0;
        running = 0;
        hold = 0;
        budget = 0;
        reqPct = 0;
        afPct = 0;
        maxLat = 1;
        cycle = 0;
        errCount = 0;
        checkCount = 0;
        testCount = 0;
        lowSeen = 0;
        curTest = "init";

        repeat (16) @(posedge clk);
        resetb <= 1'b1;
        @(negedge clk);

        startTest("reset");
        compare("reqReady", 64'(1), 64'(reqReady));
        compare("memReqEn", 64'(0), 64'(memReqEn));
        compare("rspEn0", 64'(0), 64'(rspEn[0]));
        compare("rspEn1", 64'(0), 64'(rspEn[1]));
        compare("outstanding", 64'(0), 64'(outstanding));
        endTest();
        running = 1;

        // Back to back requests wrap the tags after 15
        startTest("sequence");
        reqPct = 100;
        maxLat = 2;
        budget = kSeqReqs;
        drain();
        endTest();

        // Out of order on both lanes with back-pressure
        startTest("random");
        reqPct = 60;
        afPct = 15;
        maxLat = kMaxLat;
        lowSeen = 0;
        budget = kRandReqs;
        drain();
        assert (lowSeen > 0)
        else
        begin
            errCount++;
            $display("%s: reqReady never fell under back-pressure", curTest);
        end
        endTest();

        // Memory holds everything until the heap window closes
        startTest("fill");
        afPct = 0;
        reqPct = 100;
        hold = 1;
        lowSeen = 0;
        budget = kFillReqs;
        repeat (40) @(negedge clk);
        compare("in flight", 64'(kSlots - trackPkg::kMinFreeSlots + 1), 64'(outstanding));
        assert (lowSeen > 0)
        else
        begin
            errCount++;
            $display("%s: reqReady stayed high with the heap full", curTest);
        end
        hold = 0;
        drain();
        endTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/reqTracker_chk.sv
`timescale 1ns/10ps

module reqTrackerChk
(
    input  logic clk,
    input  logic resetb,
    input  logic reqEn,
    input  logic reqReady,
    input  logic memReqEn,
    input  logic memRspEn [trackPkg::kNumRspPorts],
    input  logic rspEn [trackPkg::kNumRspPorts]
);

    // ==============================
    // Request side
    // ==============================

    aReqGated: assert property (@(posedge clk) disable iff (!resetb) reqEn |-> reqReady)
        else $error("client request while reqReady is low");

    // Accepted request reaches the memory one cycle later
    aIssue: assert property (@(posedge clk) disable iff (!resetb)
        (reqEn && reqReady) |=> memReqEn)
        else $error("accepted request not issued next cycle");

    aNoSpurious: assert property (@(posedge clk) disable iff (!resetb)
        memReqEn |-> $past(reqEn && reqReady))
        else $error("memory request without an accepted request");

    aResetReady: assert property (@(posedge clk) $rose(resetb) |-> reqReady)
        else $error("reqReady low on first cycle after reset");

    // ==============================
    // Response lanes
    // ==============================

    for (genvar p = 0; p < trackPkg::kNumRspPorts; p++)
    begin : gLane
        aRspDelay: assert property (@(posedge clk) disable iff (!resetb)
            rspEn[p] == $past(memRspEn[p]))
            else $error("client response not one cycle after memory response");
    end

endmodule

bind reqTracker reqTrackerChk i_chk (.*);

// File: verilog/heapMulti.sv
`timescale 1ns/10ps

module heapMulti
#(
    parameter int numEntries = 32,
    parameter int dataBits = 64,
    parameter int numReadPorts = 1,
    // Free slots needed ahead of the pointer before notFull rises
    parameter int minFreeSlots = 1
)
(
    input  logic clk,
    input  logic resetb,

    // Allocation side, one enq per cycle
    input  logic enq,
    input  logic [dataBits-1:0] enqData,
    output logic notFull,
    output logic [$clog2(numEntries)-1:0] allocIdx,

    // Read ports, data one cycle after the request
    input  logic [$clog2(numEntries)-1:0] readReq [numReadPorts],
    output logic [dataBits-1:0] readRsp [numReadPorts],

    // Free ports, one per read port
    input  logic free [numReadPorts],
    input  logic [$clog2(numEntries)-1:0] freeIdx [numReadPorts]
);

    typedef logic [$clog2(numEntries)-1:0] slotT;
    typedef logic [dataBits-1:0] wordT;

    // One bit per slot, set while the slot is idle
    logic [numEntries-1:0] slotIdle;

    // Round-robin allocation pointer
    slotT nextAlloc;

    // Busy map with the low slots copied above the top
    logic [minFreeSlots+numEntries-1:0] slotIdleRepl;

    // Storage, one copy per read port
    wordT mem [numReadPorts][numEntries];

    assign allocIdx = nextAlloc;

    // ==============================
    // Allocation
    // ==============================

    // Copy lets the window run past the last slot without a modulo
    assign slotIdleRepl = {slotIdle[minFreeSlots-1:0], slotIdle};

    // Every slot in the window from the pointer must be idle
    assign notFull = &slotIdleRepl[nextAlloc +: minFreeSlots];

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            nextAlloc <= '0;
        end
        else if (enq)
        begin
            // Size need not be a power of two
            if (nextAlloc == slotT'(numEntries - 1))
            begin
                nextAlloc <= '0;
            end
            else
            begin
                nextAlloc <= nextAlloc + 1'b1;
            end
        end
    end

    // ==============================
    // Storage
    // ==============================

    // All copies take every enq, so lanes read in parallel with a write
    for (genvar p = 0; p < numReadPorts; p++)
    begin : gPort
        always_ff @(posedge clk)
        begin
            readRsp[p] <= mem[p][readReq[p]];
            if (enq)
            begin
                mem[p][nextAlloc] <= enqData;
            end
        end
    end

    // ==============================
    // Busy map
    // ==============================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            // Everything idle after reset
            slotIdle <= '1;
        end
        else
        begin
            // Allocated slot was idle, so it never collides with a free
            if (enq)
            begin
                slotIdle[nextAlloc] <= 1'b0;
            end
            for (int i = 0; i < numReadPorts; i++)
            begin
                if (free[i])
                begin
                    slotIdle[freeIdx[i]] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/reqIssue.sv
`timescale 1ns/10ps

module reqIssue
(
    input  logic clk,
    input  logic resetb,

    // Client request
    input  logic reqEn,
    input  trackPkg::reqInfoT reqInfo,
    output logic reqReady,

    // Memory back-pressure
    input  logic memAlmostFull,

    // Heap allocation port
    input  logic notFull,
    input  trackPkg::idxT allocIdx,
    output logic enq,
    output trackPkg::reqInfoT enqData,

    // Slot frees from the response lanes
    input  logic slotFree [trackPkg::kNumRspPorts],

    // Tagged request to the memory
    output logic memReqEn,
    output trackPkg::memReqT memReq,

    // Slots in flight
    output logic [trackPkg::kIdxBits:0] outstanding
);

    // Request taken this cycle
    logic accept;

    // Count after this cycle's issue and frees
    logic [trackPkg::kIdxBits:0] nextCount;

    // ==============================
    // Admission
    // ==============================

    // Room in the heap and room in the memory queue
    assign reqReady = notFull & ~memAlmostFull;
    assign accept = reqEn & reqReady;

    // Metadata goes straight into the slot at allocIdx
    assign enq = accept;
    assign enqData = reqInfo;

    // ==============================
    // Memory request
    // ==============================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memReqEn <= 1'b0;
        end
        else
        begin
            memReqEn <= accept;
        end
    end

    // Slot index becomes the tag
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            memReq.tag <= allocIdx;
            memReq.addr <= reqInfo.addr;
        end
    end

    // ==============================
    // Outstanding count
    // ==============================

    // One up per issue, one down per lane free, all in the same cycle
    always_comb
    begin
        nextCount = outstanding;
        if (accept)
        begin
            nextCount = nextCount + 1'b1;
        end
        for (int i = 0; i < trackPkg::kNumRspPorts; i++)
        begin
            if (slotFree[i])
            begin
                nextCount = nextCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            outstanding <= '0;
        end
        else
        begin
            outstanding <= nextCount;
        end
    end

endmodule

// File: verilog/reqTracker.sv
`timescale 1ns/10ps

module reqTracker
(
    input  logic clk,
    input  logic resetb,

    // Client request side
    input  logic reqEn,
    input  trackPkg::reqInfoT reqInfo,
    output logic reqReady,

    // Memory request side
    output logic memReqEn,
    output trackPkg::memReqT memReq,
    input  logic memAlmostFull,

    // Memory response lanes, any order
    input  logic memRspEn [trackPkg::kNumRspPorts],
    input  trackPkg::memRspT memRsp [trackPkg::kNumRspPorts],

    // Client response lanes
    output logic rspEn [trackPkg::kNumRspPorts],
    output trackPkg::clientRspT rsp [trackPkg::kNumRspPorts],

    // Slots in flight
    output logic [trackPkg::kIdxBits:0] outstanding
);

    // Allocation between issue stage and heap
    logic enq;
    trackPkg::reqInfoT enqData;
    logic notFull;
    trackPkg::idxT allocIdx;

    // Per-lane heap traffic
    trackPkg::idxT readReq [trackPkg::kNumRspPorts];
    trackPkg::reqInfoT readRsp [trackPkg::kNumRspPorts];
    logic free [trackPkg::kNumRspPorts];
    trackPkg::idxT freeIdx [trackPkg::kNumRspPorts];

    // ==============================
    // Issue
    // ==============================

    reqIssue i_issue
    (
        .clk(clk),
        .resetb(resetb),
        .reqEn(reqEn),
        .reqInfo(reqInfo),
        .reqReady(reqReady),
        .memAlmostFull(memAlmostFull),
        .notFull(notFull),
        .allocIdx(allocIdx),
        .enq(enq),
        .enqData(enqData),
        .slotFree(free),
        .memReqEn(memReqEn),
        .memReq(memReq),
        .outstanding(outstanding)
    );

    // ==============================
    // Heap
    // ==============================

    // Stored word is the request metadata
    heapMulti #(
        .numEntries(trackPkg::kNumEntries),
        .dataBits($bits(trackPkg::reqInfoT)),
        .numReadPorts(trackPkg::kNumRspPorts),
        .minFreeSlots(trackPkg::kMinFreeSlots)
    ) i_heap
    (
        .clk(clk),
        .resetb(resetb),
        .enq(enq),
        .enqData(enqData),
        .notFull(notFull),
        .allocIdx(allocIdx),
        .readReq(readReq),
        .readRsp(readRsp),
        .free(free),
        .freeIdx(freeIdx)
    );

    // ==============================
    // Response lanes
    // ==============================

    for (genvar p = 0; p < trackPkg::kNumRspPorts; p++)
    begin : gLane
        rspMatch i_match
        (
            .clk(clk),
            .resetb(resetb),
            .memRspEn(memRspEn[p]),
            .memRsp(memRsp[p]),
            .readReq(readReq[p]),
            .readRsp(readRsp[p]),
            .free(free[p]),
            .freeIdx(freeIdx[p]),
            .rspEn(rspEn[p]),
            .rsp(rsp[p])
        );
    end

endmodule

// File: verilog/rspMatch.sv
`timescale 1ns/10ps

module rspMatch
(
    input  logic clk,
    input  logic resetb,

    // One memory response lane
    input  logic memRspEn,
    input  trackPkg::memRspT memRsp,

    // Heap read port for this lane
    output trackPkg::idxT readReq,
    input  trackPkg::reqInfoT readRsp,

    // Heap free port for this lane
    output logic free,
    output trackPkg::idxT freeIdx,

    // Client response for this lane
    output logic rspEn,
    output trackPkg::clientRspT rsp
);

    // Response waiting one cycle for the heap read
    logic rspValid;
    logic [trackPkg::kDataBits-1:0] rspData;

    // ==============================
    // Lookup and free
    // ==============================

    // Tag is the slot, read it now and let it go at the edge
    assign readReq = memRsp.tag;

    // Read data is captured at the same edge, so freeing early is safe
    assign free = memRspEn;
    assign freeIdx = memRsp.tag;

    // ==============================
    // Join
    // ==============================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rspValid <= 1'b0;
        end
        else
        begin
            rspValid <= memRspEn;
        end
    end

    // Data lines up with the heap read one cycle later
    always_ff @(posedge clk)
    begin
        if (memRspEn)
        begin
            rspData <= memRsp.data;
        end
    end

    assign rspEn = rspValid;

    // Stored metadata plus returned data
    assign rsp.info = readRsp;
    assign rsp.data = rspData;

endmodule

// File: verilog/trackPkg.sv
package trackPkg;

    // ==============================
    // Sizes
    // ==============================

    // Heap slots, one per request in flight
    localparam int kNumEntries = 16;
    localparam int kIdxBits = 4;

    // Ring slots from the next allocation that must be free to admit a request
    localparam int kMinFreeSlots = 2;

    // Memory response lanes, also heap read and free ports
    localparam int kNumRspPorts = 2;

    // Request metadata fields
    localparam int kReqIdBits = 4;
    localparam int kUserTagBits = 8;
    localparam int kAddrBits = 20;

    // Returned read data
    localparam int kDataBits = 32;

    // ==============================
    // Types
    // ==============================

    // Heap slot index, doubles as the memory tag
    typedef logic [kIdxBits-1:0] idxT;

    // Metadata kept in the heap while a read is in flight (32 bits)
    typedef struct packed {
        logic [kReqIdBits-1:0] reqId;
        logic [kUserTagBits-1:0] userTag;
        logic [kAddrBits-1:0] addr;
    } reqInfoT;

    // Tagged read toward the memory
    typedef struct packed {
        idxT tag;
        logic [kAddrBits-1:0] addr;
    } memReqT;

    // One lane of read data from the memory
    typedef struct packed {
        idxT tag;
        logic [kDataBits-1:0] data;
    } memRspT;

    // Metadata joined to data, back to the client
    typedef struct packed {
        reqInfoT info;
        logic [kDataBits-1:0] data;
    } clientRspT;

endpackage
